//--- design/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_WIDTH      = 16;
    localparam int WORD_WIDTH      = 32;
    localparam int LINE_BYTES      = 16;
    localparam int WORDS_IN_LINE   = 4;
    localparam int NUM_LINES       = 8;
    localparam int INDEX_WIDTH     = 3;
    localparam int TAG_WIDTH       = 9;
    localparam int LINE_ADDR_WIDTH = 12;
    localparam int SB_DEPTH        = 4;

    // Derived sizes
    localparam int WORD_BYTES      = WORD_WIDTH / 8;
    localparam int LINE_WIDTH      = LINE_BYTES * 8;
    localparam int BYTE_SEL_WIDTH  = $clog2(WORD_BYTES);
    localparam int WORD_SEL_WIDTH  = $clog2(WORDS_IN_LINE);
    localparam int SB_PTR_WIDTH    = $clog2(SB_DEPTH);
    localparam int SB_COUNT_WIDTH  = $clog2(SB_DEPTH + 1);

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } access_mode_e;

    typedef enum logic [1:0] {
        INVALID,
        VALID,
        REQUESTED
    } line_state_e;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]      tag;
        logic [INDEX_WIDTH-1:0]    index;
        logic [WORD_SEL_WIDTH-1:0] word_sel;
        logic [BYTE_SEL_WIDTH-1:0] byte_sel;
    } addr_fields_t;

    // Same address, raw or split into cache fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        addr_fields_t          fields;
    } cache_addr_u;

    typedef struct packed {
        logic                  read;
        logic                  write;
        access_mode_e          mode;
        cache_addr_u           addr;
        logic [WORD_WIDTH-1:0] data;
    } cache_req_t;

    typedef struct packed {
        logic                  hit;
        logic [WORD_WIDTH-1:0] data;
    } cache_rsp_t;

    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        logic [LINE_WIDTH-1:0]      data;
    } mem_req_t;

    typedef struct packed {
        logic                       valid;
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        logic [LINE_WIDTH-1:0]      data;
    } mem_rsp_t;

    typedef struct packed {
        cache_addr_u           addr;
        logic [WORD_BYTES-1:0] mask;
        logic [WORD_WIDTH-1:0] data;
    } sb_entry_t;

    typedef struct packed {
        logic [WORD_BYTES-1:0] hit_bytes;
        logic [WORD_WIDTH-1:0] data;
        logic                  full;
        logic [NUM_LINES-1:0]  pending_lines;
    } sb_forward_t;

endpackage

//--- design/store_buffer.sv
`timescale 1ns/1ns

module store_buffer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   push,
    input  cache_pkg::sb_entry_t   entry_in,
    input  logic                   drain,
    input  cache_pkg::cache_addr_u lookup_addr,
    output cache_pkg::sb_entry_t   oldest,
    output logic                   empty,
    output cache_pkg::sb_forward_t forward
);
    import cache_pkg::*;

    sb_entry_t entries [SB_DEPTH];

    logic [SB_PTR_WIDTH-1:0]   head;
    logic [SB_PTR_WIDTH-1:0]   tail;
    logic [SB_COUNT_WIDTH-1:0] count;

    logic full;
    logic pop;
    logic push_ok;

    assign empty   = (count == '0);
    assign full    = (count == SB_COUNT_WIDTH'(SB_DEPTH));
    assign pop     = drain && !empty;
    // A full buffer still takes a push when the oldest entry leaves
    assign push_ok = push && (!full || pop);

    assign oldest = entries[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push_ok) begin
            entries[tail] <= entry_in;
        end
    end

    // Walk from oldest to newest so the newest byte wins
    always_comb begin
        logic [SB_PTR_WIDTH-1:0] slot;
        logic                    same_word;

        forward.hit_bytes     = '0;
        forward.data          = '0;
        forward.full          = full;
        forward.pending_lines = '0;

        for (int k = 0; k < SB_DEPTH; k++) begin
            slot = head + SB_PTR_WIDTH'(k);
            same_word = entries[slot].addr.raw[ADDR_WIDTH-1:BYTE_SEL_WIDTH]
                        == lookup_addr.raw[ADDR_WIDTH-1:BYTE_SEL_WIDTH];

            if (k < int'(count)) begin
                forward.pending_lines[entries[slot].addr.fields.index] = 1'b1;

                if (same_word) begin
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (entries[slot].mask[b]) begin
                            forward.hit_bytes[b]      = 1'b1;
                            forward.data[b*8 +: 8]    = entries[slot].data[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- design/line_array.sv
`timescale 1ns/1ns

module line_array (
    input  logic                   clock,
    input  logic                   reset,
    input  cache_pkg::cache_req_t  req,
    output cache_pkg::cache_rsp_t  rsp,
    output logic                   push,
    output logic                   drain,
    output cache_pkg::sb_entry_t   push_entry,
    input  cache_pkg::sb_entry_t   oldest,
    input  logic                   sb_empty,
    input  cache_pkg::sb_forward_t forward,
    input  logic                   bus_free,
    output cache_pkg::mem_req_t    mem_out,
    input  cache_pkg::mem_rsp_t    fill
);
    import cache_pkg::*;

    line_state_e            states [NUM_LINES];
    logic [LINE_BYTES-1:0]  dirty  [NUM_LINES];
    logic [TAG_WIDTH-1:0]   tags   [NUM_LINES];
    logic [LINE_WIDTH-1:0]  lines  [NUM_LINES];

    logic [INDEX_WIDTH-1:0]    idx;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    logic [BYTE_SEL_WIDTH-1:0] byte_sel;
    line_state_e               state;
    logic                      tag_match;

    logic [WORD_BYTES-1:0] req_mask;
    logic [WORD_BYTES-1:0] array_bytes;
    logic [WORD_BYTES-1:0] found_bytes;
    logic [WORD_WIDTH-1:0] array_word;
    logic [WORD_WIDTH-1:0] merged;

    logic read_hit;
    logic write_hit;
    logic miss_ok;
    logic other_tag;
    logic line_dirty;
    logic line_pending;

    logic [INDEX_WIDTH-1:0]    fill_idx;
    logic [INDEX_WIDTH-1:0]    drain_idx;
    logic [WORD_SEL_WIDTH-1:0] drain_word;

    assign idx       = req.addr.fields.index;
    assign word_sel  = req.addr.fields.word_sel;
    assign byte_sel  = req.addr.fields.byte_sel;
    assign state     = states[idx];
    assign tag_match = (tags[idx] == req.addr.fields.tag);

    // Accesses are aligned, so a shift of the base mask is enough
    always_comb begin
        case (req.mode)
            BYTE:    req_mask = 4'b0001 << byte_sel;
            HALF:    req_mask = 4'b0011 << byte_sel;
            default: req_mask = 4'b1111;
        endcase
    end

    // Requested lines only hold the bytes already written into them
    assign array_bytes = tag_match
        ? ({WORD_BYTES{state == VALID}}
           | ({WORD_BYTES{state == REQUESTED}} & dirty[idx][word_sel*WORD_BYTES +: WORD_BYTES]))
        : '0;
    assign array_word  = lines[idx][word_sel*WORD_WIDTH +: WORD_WIDTH];
    assign found_bytes = array_bytes | forward.hit_bytes;

    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            merged[b*8 +: 8] = forward.hit_bytes[b] ? forward.data[b*8 +: 8]
                                                    : array_word[b*8 +: 8];
        end
    end

    always_comb begin
        case (req.mode)
            BYTE:    rsp.data = {{(WORD_WIDTH-8){1'b0}}, merged[byte_sel*8 +: 8]};
            HALF:    rsp.data = {{(WORD_WIDTH-16){1'b0}}, merged[byte_sel[1]*16 +: 16]};
            default: rsp.data = merged;
        endcase
    end

    assign read_hit  = &(found_bytes | ~req_mask);
    assign drain     = !sb_empty && !fill.valid;
    assign write_hit = (state != INVALID) && tag_match && (!forward.full || drain);
    assign rsp.hit   = (req.read && read_hit) || (req.write && write_hit);

    // Store data goes into every lane, the mask picks the real ones
    assign push            = req.write && write_hit;
    assign push_entry.addr = req.addr;
    assign push_entry.mask = req_mask;
    always_comb begin
        case (req.mode)
            BYTE:    push_entry.data = {WORD_BYTES{req.data[7:0]}};
            HALF:    push_entry.data = {(WORD_WIDTH/16){req.data[15:0]}};
            default: push_entry.data = req.data;
        endcase
    end

    // Miss handling, a line with stores still queued is left alone
    assign miss_ok      = req.read && !read_hit && bus_free;
    assign other_tag    = (state == VALID) && !tag_match;
    assign line_dirty   = |dirty[idx];
    assign line_pending = forward.pending_lines[idx];

    assign mem_out.write     = miss_ok && other_tag && line_dirty && !line_pending;
    assign mem_out.read      = miss_ok
                               && (state == INVALID
                                   || (other_tag && !line_dirty && !line_pending));
    assign mem_out.line_addr = mem_out.write ? {tags[idx], idx}
                                             : {req.addr.fields.tag, idx};
    assign mem_out.data      = lines[idx];

    assign fill_idx   = fill.line_addr[INDEX_WIDTH-1:0];
    assign drain_idx  = oldest.addr.fields.index;
    assign drain_word = oldest.addr.fields.word_sel;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                states[i] <= INVALID;
                dirty[i]  <= '0;
            end
        end else begin
            if (mem_out.read) begin
                states[idx] <= REQUESTED;
            end else if (mem_out.write) begin
                states[idx] <= INVALID;
                dirty[idx]  <= '0;
            end
            // Bytes stored while waiting stay dirty for the next write-back
            if (fill.valid) begin
                states[fill_idx] <= VALID;
            end
            if (drain) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (oldest.mask[b]) begin
                        dirty[drain_idx][drain_word*WORD_BYTES + b] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        // Tag moves with the request so stores to the new line hit
        if (mem_out.read) begin
            tags[idx] <= req.addr.fields.tag;
        end
        if (fill.valid) begin
            tags[fill_idx] <= fill.line_addr[LINE_ADDR_WIDTH-1:INDEX_WIDTH];
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (!dirty[fill_idx][b]) begin
                    lines[fill_idx][b*8 +: 8] <= fill.data[b*8 +: 8];
                end
            end
        end
        if (drain) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (oldest.mask[b]) begin
                    lines[drain_idx][drain_word*WORD_WIDTH + b*8 +: 8] <= oldest.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- design/mem_bus_port.sv
`timescale 1ns/1ns

module mem_bus_port (
    input  logic                clock,
    input  logic                reset,
    input  cache_pkg::mem_req_t line_req,
    output logic                bus_free,
    output cache_pkg::mem_req_t bus_req,
    input  cache_pkg::mem_rsp_t bus_rsp,
    output cache_pkg::mem_rsp_t fill
);
    import cache_pkg::*;

    mem_req_t req_q;
    mem_rsp_t rsp_q;
    logic     read_busy;
    logic     accept_read;
    logic     accept_write;

    assign accept_read  = line_req.read && bus_free;
    assign accept_write = line_req.write && bus_free;

    // Outgoing request, live for exactly one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            req_q.read  <= 1'b0;
            req_q.write <= 1'b0;
        end else begin
            req_q.read      <= accept_read;
            req_q.write     <= accept_write;
            req_q.line_addr <= line_req.line_addr;
            req_q.data      <= line_req.data;
        end
    end

    // Only one read may be in flight
    always_ff @(posedge clock) begin
        if (reset) begin
            read_busy <= 1'b0;
        end else if (accept_read) begin
            read_busy <= 1'b1;
        end else if (bus_rsp.valid) begin
            read_busy <= 1'b0;
        end
    end

    // Fill reaches the line array one cycle after the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_q.valid <= 1'b0;
        end else begin
            rsp_q.valid     <= bus_rsp.valid;
            rsp_q.line_addr <= bus_rsp.line_addr;
            rsp_q.data      <= bus_rsp.data;
        end
    end

    // A write holds the bus only while it is on the wires
    assign bus_free = !read_busy && !req_q.write;
    assign bus_req  = req_q;
    assign fill     = rsp_q;

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ns

module cache_top (
    input  logic                  clock,
    input  logic                  reset,
    input  cache_pkg::cache_req_t req,
    output cache_pkg::cache_rsp_t rsp,
    output cache_pkg::mem_req_t   bus_req,
    input  cache_pkg::mem_rsp_t   bus_rsp
);
    import cache_pkg::*;

    logic        push;
    logic        drain;
    logic        sb_empty;
    logic        bus_free;
    sb_entry_t   push_entry;
    sb_entry_t   oldest;
    sb_forward_t forward;
    mem_req_t    line_req;
    mem_rsp_t    fill;

    store_buffer u_store_buffer (
        .clock       (clock),
        .reset       (reset),
        .push        (push),
        .entry_in    (push_entry),
        .drain       (drain),
        .lookup_addr (req.addr),
        .oldest      (oldest),
        .empty       (sb_empty),
        .forward     (forward)
    );

    line_array u_line_array (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .rsp        (rsp),
        .push       (push),
        .drain      (drain),
        .push_entry (push_entry),
        .oldest     (oldest),
        .sb_empty   (sb_empty),
        .forward    (forward),
        .bus_free   (bus_free),
        .mem_out    (line_req),
        .fill       (fill)
    );

    mem_bus_port u_mem_bus_port (
        .clock    (clock),
        .reset    (reset),
        .line_req (line_req),
        .bus_free (bus_free),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .fill     (fill)
    );

endmodule

//--- sim/main_memory.sv
`timescale 1ns/1ns

module main_memory #(
    parameter int SEED = 1
) (
    input  logic                clock,
    input  logic                reset,
    input  cache_pkg::mem_req_t bus_req,
    output cache_pkg::mem_rsp_t bus_rsp
);
    import cache_pkg::*;

    logic [7:0] image [0:(1 << ADDR_WIDTH) - 1];

    int                         seed;
    logic                       pending;
    int                         wait_cycles;
    logic [LINE_ADDR_WIDTH-1:0] pending_addr;

    function automatic logic [7:0] initial_byte(input logic [ADDR_WIDTH-1:0] a);
        return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h6b;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] read_line(
        input logic [LINE_ADDR_WIDTH-1:0] line_addr
    );
        logic [LINE_WIDTH-1:0] data;
        for (int j = 0; j < LINE_BYTES; j++) begin
            data[j*8 +: 8] = image[{line_addr, 4'(j)}];
        end
        return data;
    endfunction

    initial begin
        seed         = SEED;
        pending      = 1'b0;
        wait_cycles  = 0;
        pending_addr = '0;
        bus_rsp      = '0;
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            image[a] = initial_byte(ADDR_WIDTH'(a));
        end
    end

    // Registered bus request is stable a little after the edge
    always @(posedge clock) begin
        #2;
        bus_rsp.valid = 1'b0;
        if (reset) begin
            pending = 1'b0;
        end else begin
            if (pending) begin
                if (wait_cycles == 0) begin
                    bus_rsp.valid     = 1'b1;
                    bus_rsp.line_addr = pending_addr;
                    bus_rsp.data      = read_line(pending_addr);
                    pending           = 1'b0;
                end else begin
                    wait_cycles--;
                end
            end
            if (bus_req.write) begin
                for (int j = 0; j < LINE_BYTES; j++) begin
                    image[{bus_req.line_addr, 4'(j)}] = bus_req.data[j*8 +: 8];
                end
            end
            // Answer 2 to 6 cycles after the read
            if (bus_req.read) begin
                pending      = 1'b1;
                pending_addr = bus_req.line_addr;
                wait_cycles  = 1 + (($random(seed) & 32'h7fff_ffff) % 5);
            end
        end
    end

endmodule

//--- sim/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;
    import cache_pkg::*;

    localparam int CLOCK_PERIOD   = 20;
    localparam int NUM_ACCESSES   = 400;
    localparam int RETRY_LIMIT    = 40;
    localparam int NUM_WORDS      = 24;
    localparam int WATCHDOG_NS    = NUM_ACCESSES * 60 * CLOCK_PERIOD;
    localparam int NUM_LINE_ADDRS = 1 << LINE_ADDR_WIDTH;

    logic       clock;
    logic       reset;
    cache_req_t req;
    cache_rsp_t rsp;
    mem_req_t   bus_req;
    mem_rsp_t   bus_rsp;

    logic [7:0] model   [0:(1 << ADDR_WIDTH) - 1];
    logic       touched [0:NUM_LINE_ADDRS-1];
    logic       fetched [0:NUM_LINE_ADDRS-1];

    int seed;
    int error_count;
    int hit_fail_count;

    cache_top uut (
        .clock   (clock),
        .reset   (reset),
        .req     (req),
        .rsp     (rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    main_memory #(.SEED(97638)) mem (
        .clock   (clock),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic int rand_below(input int limit);
        int value;
        value = $random(seed) & 32'h7fff_ffff;
        return value % limit;
    endfunction

    // Three tags share the eight indices
    function automatic logic [ADDR_WIDTH-1:0] pick_address(
        input int word_pick, input access_mode_e mode
    );
        cache_addr_u a;
        int          group;
        group = word_pick / 8;
        case (group)
            0:       a.fields.tag = 9'h02a;
            1:       a.fields.tag = 9'h0d5;
            default: a.fields.tag = 9'h163;
        endcase
        a.fields.index    = INDEX_WIDTH'(word_pick % 8);
        a.fields.word_sel = WORD_SEL_WIDTH'((word_pick + group) % 4);
        case (mode)
            BYTE:    a.fields.byte_sel = BYTE_SEL_WIDTH'(rand_below(4));
            HALF:    a.fields.byte_sel = BYTE_SEL_WIDTH'(2 * rand_below(2));
            default: a.fields.byte_sel = '0;
        endcase
        return a.raw;
    endfunction

    function automatic logic [WORD_WIDTH-1:0] expected_read(
        input access_mode_e mode, input logic [ADDR_WIDTH-1:0] addr
    );
        logic [WORD_WIDTH-1:0] word;
        word = {model[addr + 16'd3], model[addr + 16'd2], model[addr + 16'd1], model[addr]};
        case (mode)
            BYTE:    return {24'h0, word[7:0]};
            HALF:    return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic void update_model(
        input access_mode_e mode, input logic [ADDR_WIDTH-1:0] addr,
        input logic [WORD_WIDTH-1:0] data
    );
        int count;
        case (mode)
            BYTE:    count = 1;
            HALF:    count = 2;
            default: count = 4;
        endcase
        for (int b = 0; b < count; b++) begin
            model[addr + 16'(b)] = data[b*8 +: 8];
        end
    endfunction

    function automatic logic [LINE_WIDTH-1:0] model_line(
        input logic [LINE_ADDR_WIDTH-1:0] line_addr
    );
        logic [LINE_WIDTH-1:0] bytes;
        for (int j = 0; j < LINE_BYTES; j++) begin
            bytes[j*8 +: 8] = model[{line_addr, 4'(j)}];
        end
        return bytes;
    endfunction

    // One request per cycle with the response taken at the falling edge
    task automatic drive_cycle(
        input logic do_read, input logic do_write, input access_mode_e mode,
        input logic [ADDR_WIDTH-1:0] addr, input logic [WORD_WIDTH-1:0] data,
        output logic hit, output logic [WORD_WIDTH-1:0] rdata
    );
        @(posedge clock);
        #2;
        req.read     = do_read;
        req.write    = do_write;
        req.mode     = mode;
        req.addr.raw = addr;
        req.data     = data;
        @(negedge clock);
        hit   = rsp.hit;
        rdata = rsp.data;
    endtask

    task automatic check_quiet();
        assert (!rsp.hit && !bus_req.read && !bus_req.write) else begin
            error_count++;
            $display("Error: around reset rsp.hit=%h bus_req.read=%h bus_req.write=%h",
                     rsp.hit, bus_req.read, bus_req.write);
        end
    endtask

    task automatic read_until_hit(input access_mode_e mode, input logic [ADDR_WIDTH-1:0] addr);
        logic                       hit;
        logic                       first_read;
        logic [WORD_WIDTH-1:0]      rdata;
        logic [WORD_WIDTH-1:0]      expected;
        logic [LINE_ADDR_WIDTH-1:0] line;
        int                         tries;

        line          = addr[ADDR_WIDTH-1:ADDR_WIDTH-LINE_ADDR_WIDTH];
        first_read    = !touched[line];
        touched[line] = 1'b1;
        hit           = 1'b0;
        tries         = 0;
        while (!hit && tries < RETRY_LIMIT) begin
            drive_cycle(1'b1, 1'b0, mode, addr, '0, hit, rdata);
            if (first_read && tries == 0) begin
                assert (!hit) else begin
                    error_count++;
                    $display("First read of line %h hit before the line was fetched", line);
                end
            end
            tries++;
        end
        assert (hit) else begin
            hit_fail_count++;
            $display("Read at address %h never hit within %0d cycles", addr, RETRY_LIMIT);
        end
        if (hit) begin
            expected = expected_read(mode, addr);
            assert (rdata == expected) else begin
                error_count++;
                $display("Error: rsp.data for %s read at %h: got %h, expected %h",
                         mode.name(), addr, rdata, expected);
            end
            if (first_read) begin
                assert (fetched[line]) else begin
                    error_count++;
                    $display("No bus read for line %h came before its first read hit", line);
                end
            end
        end
    endtask

    task automatic write_access(
        input access_mode_e mode, input logic [ADDR_WIDTH-1:0] addr,
        input logic [WORD_WIDTH-1:0] data
    );
        logic                       hit;
        logic                       never_read;
        logic [WORD_WIDTH-1:0]      rdata;
        logic [WORD_WIDTH-1:0]      expected;
        logic [LINE_ADDR_WIDTH-1:0] line;
        int                         tries;

        line       = addr[ADDR_WIDTH-1:ADDR_WIDTH-LINE_ADDR_WIDTH];
        never_read = !touched[line];
        drive_cycle(1'b0, 1'b1, mode, addr, data, hit, rdata);
        if (never_read) begin
            assert (!hit) else begin
                error_count++;
                $display("Write at %h hit although line %h was never read", addr, line);
            end
        end
        // Bring the line in after a miss and retry the write
        if (!hit) begin
            read_until_hit(mode, addr);
            tries = 0;
            while (!hit && tries < RETRY_LIMIT) begin
                drive_cycle(1'b0, 1'b1, mode, addr, data, hit, rdata);
                tries++;
            end
            assert (hit) else begin
                hit_fail_count++;
                $display("Write at address %h never hit within %0d cycles", addr, RETRY_LIMIT);
            end
        end
        if (hit) begin
            update_model(mode, addr, data);
            drive_cycle(1'b1, 1'b0, mode, addr, '0, hit, rdata);
            expected = expected_read(mode, addr);
            assert (hit) else begin
                error_count++;
                $display("Read right after the write at %h missed instead of forwarding", addr);
            end
            assert (!hit || rdata == expected) else begin
                error_count++;
                $display("Error: rsp.data forwarded at %h: got %h, expected %h",
                         addr, rdata, expected);
            end
        end
    endtask

    // Bus traffic is registered, so it is settled shortly after the edge
    always @(posedge clock) begin
        #1;
        if (!reset && bus_req.write) begin
            assert (bus_req.data == model_line(bus_req.line_addr)) else begin
                error_count++;
                $display("Error: bus_req.data for line %h: got %h, expected %h",
                         bus_req.line_addr, bus_req.data, model_line(bus_req.line_addr));
            end
        end
        if (!reset && bus_req.read) begin
            fetched[bus_req.line_addr] = 1'b1;
        end
    end

    initial begin
        int                    word_pick;
        access_mode_e          mode;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] data;

        seed           = 97638;
        error_count    = 0;
        hit_fail_count = 0;
        clock          = 1'b0;
        reset          = 1'b1;
        req            = '0;
        // Write to a line that cannot be valid yet
        req.write      = 1'b1;
        req.mode       = WORD;
        req.addr.raw   = 16'h2a40;
        for (int i = 0; i < NUM_LINE_ADDRS; i++) begin
            touched[i] = 1'b0;
            fetched[i] = 1'b0;
        end

        @(negedge clock);
        check_quiet();
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            model[a] = mem.image[a];
        end
        @(negedge clock);
        check_quiet();
        @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        check_quiet();

        for (int n = 0; n < NUM_ACCESSES; n++) begin
            word_pick = rand_below(NUM_WORDS);
            mode      = access_mode_e'(rand_below(3));
            addr      = pick_address(word_pick, mode);
            data      = $random(seed);
            if (rand_below(2) == 1) begin
                write_access(mode, addr, data);
            end else begin
                read_until_hit(mode, addr);
            end
        end

        @(posedge clock);
        #2;
        req = '0;
        @(negedge clock);
        $display("Accesses: %0d, errors: %0d, accesses without hit: %0d",
                 NUM_ACCESSES, error_count, hit_fail_count);
        if (error_count == 0 && hit_fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before all accesses finished", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- project.f
design/cache_pkg.sv
design/store_buffer.sv
design/line_array.sv
design/mem_bus_port.sv
design/cache_top.sv
sim/main_memory.sv
sim/cache_tb.sv

//--- Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only if the simulation output holds the pass message
run: compile
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
